//--- rtl/crd_macros.svh
`ifndef CRD_MACROS_SVH
`define CRD_MACROS_SVH

// receiver buffer depth, also the starting credit count of a sender.
`define CRD_DEPTH 4
`define CRD_CNT_W 3

`define CRD_ADDR_W 16
`define CRD_DATA_W 16

`endif

//--- rtl/crd_pkg.sv
`default_nettype none

`include "crd_macros.svh"

package crd_pkg;

  typedef struct packed {
    logic [`CRD_ADDR_W-1:0] addr;
  } ld_item_t;

  typedef struct packed {
    logic [`CRD_ADDR_W-1:0] addr;
    logic [`CRD_DATA_W-1:0] data;
  } st_item_t;

  typedef enum logic {
    OUT_LD = 1'b0,
    OUT_ST = 1'b1
  } out_kind_e;

  typedef struct packed {
    out_kind_e              kind;
    logic [`CRD_ADDR_W-1:0] addr;
    logic [`CRD_DATA_W-1:0] data; // zero for loads.
  } out_item_t;

endpackage

`default_nettype wire

//--- rtl/crd_lane_if.sv
`default_nettype none

`include "crd_macros.svh"

interface crd_lane_if import crd_pkg::*; #(
  parameter type payload_t = ld_item_t
) ();

  logic                  valid;     // one pulse per item.
  payload_t              payload;
  logic                  ret_valid; // one pulse per credit return.
  logic [`CRD_CNT_W-1:0] ret_count;

  modport sender (
    output valid,
    output payload,
    input  ret_valid,
    input  ret_count
  );

  modport receiver (
    input  valid,
    input  payload,
    output ret_valid,
    output ret_count
  );

endinterface

`default_nettype wire

//--- rtl/credit_sender.sv
`default_nettype none

`include "crd_macros.svh"

module credit_sender import crd_pkg::*; #(
  parameter type payload_t = ld_item_t
) (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_send,
  input  payload_t              i_payload,
  output logic                  o_ready,
  output logic [`CRD_CNT_W-1:0] o_credits,
  crd_lane_if.sender            lane
);

  logic [`CRD_CNT_W-1:0] r_credits;
  logic [`CRD_CNT_W-1:0] w_ret;
  logic                  w_launch;
  logic                  r_valid;
  payload_t              r_payload;

  // a send with no credit left is simply dropped.
  assign w_launch = i_send && (r_credits != '0);
  assign w_ret    = lane.ret_valid ? lane.ret_count : '0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_credits <= `CRD_CNT_W'(`CRD_DEPTH);
      r_valid   <= 1'b0;
    end else begin
      r_credits <= r_credits - {{(`CRD_CNT_W-1){1'b0}}, w_launch} + w_ret;
      r_valid   <= w_launch;
    end
  end

  always_ff @(posedge i_clk) begin
    if (w_launch) begin
      r_payload <= i_payload;
    end
  end

  assign lane.valid   = r_valid;
  assign lane.payload = r_payload;

  assign o_ready   = (r_credits != '0);
  assign o_credits = r_credits;

  a_credit_bound : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    r_credits <= `CRD_CNT_W'(`CRD_DEPTH)
  );

  // the receiver may only hand back credits that are actually out on the lane.
  a_return_fits : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    lane.ret_valid |->
      ({1'b0, r_credits} + {1'b0, lane.ret_count}) <= (`CRD_DEPTH + w_launch)
  );

endmodule

`default_nettype wire

//--- rtl/credit_receiver.sv
`default_nettype none

`include "crd_macros.svh"

module credit_receiver import crd_pkg::*; #(
  parameter type payload_t = ld_item_t
) (
  input  logic         i_clk,
  input  logic         i_reset_n,
  crd_lane_if.receiver lane,
  input  logic         i_pop,
  output logic         o_head_valid,
  output payload_t     o_head
);

  localparam int PTR_W = $clog2(`CRD_DEPTH);

  payload_t              mem [`CRD_DEPTH];
  logic [PTR_W-1:0]      r_wr_ptr;
  logic [PTR_W-1:0]      r_rd_ptr;
  logic [`CRD_CNT_W-1:0] r_count;
  logic                  r_ret_valid;
  logic                  w_full;

  assign w_full = (r_count == `CRD_CNT_W'(`CRD_DEPTH));

  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(`CRD_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  always_ff @(posedge i_clk) begin
    if (lane.valid) begin
      mem[r_wr_ptr] <= lane.payload;
    end
  end

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_wr_ptr    <= '0;
      r_rd_ptr    <= '0;
      r_count     <= '0;
      r_ret_valid <= 1'b0;
    end else begin
      if (lane.valid) begin
        r_wr_ptr <= ptr_next(r_wr_ptr);
      end
      if (i_pop) begin
        r_rd_ptr <= ptr_next(r_rd_ptr);
      end
      r_count     <= r_count + {{(`CRD_CNT_W-1){1'b0}}, lane.valid}
                             - {{(`CRD_CNT_W-1){1'b0}}, i_pop};
      r_ret_valid <= i_pop; // each freed slot goes back as one credit.
    end
  end

  assign lane.ret_valid = r_ret_valid;
  assign lane.ret_count = `CRD_CNT_W'(1);

  assign o_head_valid = (r_count != '0);
  assign o_head       = mem[r_rd_ptr];

  // an item arriving at a full buffer means the sender overran its credits.
  a_no_overflow : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    lane.valid |-> !w_full
  );

  a_no_underflow : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    i_pop |-> o_head_valid
  );

endmodule

`default_nettype wire

//--- rtl/lane_merge.sv
`default_nettype none

`include "crd_macros.svh"

module lane_merge import crd_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset_n,
  input  logic      i_ld_valid,
  input  ld_item_t  i_ld_head,
  input  logic      i_st_valid,
  input  st_item_t  i_st_head,
  output logic      o_ld_pop,
  output logic      o_st_pop,
  output logic      o_out_valid,
  output out_item_t o_out,
  input  logic      i_out_ready
);

  out_kind_e r_prio;      // lane that wins when both heads are present.
  logic      r_hold;      // output was stalled last cycle.
  out_kind_e r_hold_lane;
  logic      w_both;
  logic      w_sel_st;
  logic      w_take;

  assign w_both = i_ld_valid && i_st_valid;

  // a stalled choice stays put, so a late arrival cannot swap the output.
  always_comb begin
    if (r_hold) begin
      w_sel_st = (r_hold_lane == OUT_ST);
    end else if (w_both) begin
      w_sel_st = (r_prio == OUT_ST);
    end else begin
      w_sel_st = i_st_valid;
    end
  end

  assign o_out_valid = i_ld_valid || i_st_valid;
  assign w_take      = o_out_valid && i_out_ready;
  assign o_ld_pop    = w_take && !w_sel_st;
  assign o_st_pop    = w_take && w_sel_st;

  assign o_out.kind = w_sel_st ? OUT_ST : OUT_LD;
  assign o_out.addr = w_sel_st ? i_st_head.addr : i_ld_head.addr;
  assign o_out.data = w_sel_st ? i_st_head.data : '0;

  always_ff @(posedge i_clk or negedge i_reset_n) begin
    if (!i_reset_n) begin
      r_prio      <= OUT_LD;
      r_hold      <= 1'b0;
      r_hold_lane <= OUT_LD;
    end else begin
      if (w_take && w_both) begin
        r_prio <= w_sel_st ? OUT_LD : OUT_ST;
      end
      r_hold      <= o_out_valid && !i_out_ready;
      r_hold_lane <= o_out.kind;
    end
  end

  // a pop always takes a head that is present, even on a held choice.
  a_pop_has_head : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    !(o_ld_pop && !i_ld_valid) && !(o_st_pop && !i_st_valid)
  );

  a_stall_stable : assert property (
    @(posedge i_clk) disable iff (!i_reset_n)
    (o_out_valid && !i_out_ready) |=> (o_out_valid && $stable(o_out))
  );

endmodule

`default_nettype wire

//--- rtl/credit_link_top.sv
`default_nettype none

`include "crd_macros.svh"

module credit_link_top import crd_pkg::*; (
  input  logic                  i_clk,
  input  logic                  i_reset_n,
  input  logic                  i_ld_send,
  input  logic [`CRD_ADDR_W-1:0] i_ld_addr,
  output logic                  o_ld_ready,
  output logic [`CRD_CNT_W-1:0] o_ld_credits,
  input  logic                  i_st_send,
  input  logic [`CRD_ADDR_W-1:0] i_st_addr,
  input  logic [`CRD_DATA_W-1:0] i_st_data,
  output logic                  o_st_ready,
  output logic [`CRD_CNT_W-1:0] o_st_credits,
  output logic                  o_out_valid,
  input  logic                  i_out_ready,
  output logic                  o_out_kind,
  output logic [`CRD_ADDR_W-1:0] o_out_addr,
  output logic [`CRD_DATA_W-1:0] o_out_data
);

  ld_item_t  w_ld_in;
  st_item_t  w_st_in;
  logic      w_ld_head_valid;
  ld_item_t  w_ld_head;
  logic      w_ld_pop;
  logic      w_st_head_valid;
  st_item_t  w_st_head;
  logic      w_st_pop;
  out_item_t w_out;

  assign w_ld_in.addr = i_ld_addr;
  assign w_st_in.addr = i_st_addr;
  assign w_st_in.data = i_st_data;

  crd_lane_if #(.payload_t(ld_item_t)) ld_lane ();
  crd_lane_if #(.payload_t(st_item_t)) st_lane ();

  credit_sender #(.payload_t(ld_item_t)) u_ld_sender (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_send    (i_ld_send),
    .i_payload (w_ld_in),
    .o_ready   (o_ld_ready),
    .o_credits (o_ld_credits),
    .lane      (ld_lane.sender)
  );

  credit_sender #(.payload_t(st_item_t)) u_st_sender (
    .i_clk     (i_clk),
    .i_reset_n (i_reset_n),
    .i_send    (i_st_send),
    .i_payload (w_st_in),
    .o_ready   (o_st_ready),
    .o_credits (o_st_credits),
    .lane      (st_lane.sender)
  );

  credit_receiver #(.payload_t(ld_item_t)) u_ld_receiver (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .lane         (ld_lane.receiver),
    .i_pop        (w_ld_pop),
    .o_head_valid (w_ld_head_valid),
    .o_head       (w_ld_head)
  );

  credit_receiver #(.payload_t(st_item_t)) u_st_receiver (
    .i_clk        (i_clk),
    .i_reset_n    (i_reset_n),
    .lane         (st_lane.receiver),
    .i_pop        (w_st_pop),
    .o_head_valid (w_st_head_valid),
    .o_head       (w_st_head)
  );

  lane_merge u_merge (
    .i_clk       (i_clk),
    .i_reset_n   (i_reset_n),
    .i_ld_valid  (w_ld_head_valid),
    .i_ld_head   (w_ld_head),
    .i_st_valid  (w_st_head_valid),
    .i_st_head   (w_st_head),
    .o_ld_pop    (w_ld_pop),
    .o_st_pop    (w_st_pop),
    .o_out_valid (o_out_valid),
    .o_out       (w_out),
    .i_out_ready (i_out_ready)
  );

  assign o_out_kind = w_out.kind;
  assign o_out_addr = w_out.addr;
  assign o_out_data = w_out.data;

endmodule

`default_nettype wire

//--- test/credit_link_tb.sv
`default_nettype none

`include "crd_macros.svh"

module credit_link_tb;

  typedef struct {
    string       name;
    int          cycles;
    bit          ld_send;
    bit          st_send;
    bit          ready;
    bit          rnd;
    logic [15:0] base;
  } row_t;

  logic                   i_clk;
  logic                   i_reset_n;
  logic                   i_ld_send;
  logic [`CRD_ADDR_W-1:0] i_ld_addr;
  logic                   i_st_send;
  logic [`CRD_ADDR_W-1:0] i_st_addr;
  logic [`CRD_DATA_W-1:0] i_st_data;
  logic                   i_out_ready;
  logic                   o_ld_ready;
  logic                   o_st_ready;
  logic [`CRD_CNT_W-1:0]  o_ld_credits;
  logic [`CRD_CNT_W-1:0]  o_st_credits;
  logic                   o_out_valid;
  logic                   o_out_kind;
  logic [`CRD_ADDR_W-1:0] o_out_addr;
  logic [`CRD_DATA_W-1:0] o_out_data;

  row_t        rows[$];
  logic [31:0] lcg_state = 32'ha2d9;
  int          cycle_count = 0;
  int          cycle_limit = 1000;

  // reference model of both lanes and the merge.
  int                                 m_ld_cred;
  int                                 m_st_cred;
  bit                                 m_ld_ret, m_st_ret;   // credit return on its way back.
  bit                                 m_ld_fl, m_st_fl;     // item on the lane this cycle.
  logic [`CRD_ADDR_W-1:0]             m_ld_fl_item;
  logic [`CRD_ADDR_W+`CRD_DATA_W-1:0] m_st_fl_item;
  logic [`CRD_ADDR_W-1:0]             ld_q[$];
  logic [`CRD_ADDR_W+`CRD_DATA_W-1:0] st_q[$];              // {addr, data}.
  bit                                 m_prio_st, m_hold, m_hold_st;

  credit_link_top DUT (.*);

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  always @(posedge i_clk) begin
    cycle_count++;
    if (cycle_count > cycle_limit) begin
      $display("timeout: the run went past %0d clock cycles", cycle_limit);
      $display("Testbench failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic compare_value(input string name, input string what,
                               input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERR %s %s: expected %0h actual %0h", name, what, exp, act);
      $display("Testbench failed");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic add_row(input string name, input int cycles, input bit ld, input bit st,
                         input bit rdy, input bit rnd, input logic [15:0] base);
    row_t r;
    r.name    = name;
    r.cycles  = cycles;
    r.ld_send = ld;
    r.st_send = st;
    r.ready   = rdy;
    r.rnd     = rnd;
    r.base    = base;
    rows.push_back(r);
  endtask

  // a stalled choice is kept, otherwise priority decides between two heads.
  function automatic bit select_st();
    if (m_hold) begin
      return m_hold_st;
    end else if (ld_q.size() != 0 && st_q.size() != 0) begin
      return m_prio_st;
    end
    return st_q.size() != 0;
  endfunction

  task automatic check_outputs(input string name);
    bit sel;
    sel = select_st();
    compare_value(name, "ld credits", m_ld_cred, o_ld_credits);
    compare_value(name, "st credits", m_st_cred, o_st_credits);
    compare_value(name, "ld ready", m_ld_cred != 0, o_ld_ready);
    compare_value(name, "st ready", m_st_cred != 0, o_st_ready);
    compare_value(name, "out valid", ld_q.size() != 0 || st_q.size() != 0, o_out_valid);
    if (ld_q.size() != 0 || st_q.size() != 0) begin
      compare_value(name, "out kind", sel, o_out_kind);
      compare_value(name, "out addr", sel ? st_q[0][31:16] : ld_q[0], o_out_addr);
      compare_value(name, "out data", sel ? st_q[0][15:0] : 16'h0, o_out_data);
    end
  endtask

  // advances the model across the next rising edge with the inputs just driven.
  task automatic model_step();
    bit both, valid, sel, take, ld_go, st_go;
    both  = ld_q.size() != 0 && st_q.size() != 0;
    valid = ld_q.size() != 0 || st_q.size() != 0;
    sel   = select_st();
    take  = valid && i_out_ready;
    ld_go = i_ld_send && m_ld_cred != 0;
    st_go = i_st_send && m_st_cred != 0;
    m_ld_cred = m_ld_cred - ld_go + m_ld_ret;
    m_st_cred = m_st_cred - st_go + m_st_ret;
    m_ld_ret  = take && !sel;
    m_st_ret  = take && sel;
    if (take && !sel) void'(ld_q.pop_front());
    if (take && sel) void'(st_q.pop_front());
    if (m_ld_fl) ld_q.push_back(m_ld_fl_item);
    if (m_st_fl) st_q.push_back(m_st_fl_item);
    m_ld_fl = ld_go;
    m_st_fl = st_go;
    if (ld_go) m_ld_fl_item = i_ld_addr;
    if (st_go) m_st_fl_item = {i_st_addr, i_st_data};
    if (take && both) m_prio_st = !sel;
    m_hold    = valid && !i_out_ready;
    m_hold_st = sel;
  endtask

  initial begin
    int          total;
    logic [31:0] r;
    i_reset_n   = 1'b0;
    i_ld_send   = 1'b0;
    i_ld_addr   = '0;
    i_st_send   = 1'b0;
    i_st_addr   = '0;
    i_st_data   = '0;
    i_out_ready = 1'b1;
    m_ld_cred   = `CRD_DEPTH;
    m_st_cred   = `CRD_DEPTH;

    add_row("reset_idle", 2, 0, 0, 1, 0, 16'h0000);
    add_row("ld_order", 3, 1, 0, 1, 0, 16'h1000);
    add_row("st_order", 3, 0, 1, 1, 0, 16'h2000);
    add_row("drain", 4, 0, 0, 1, 0, 16'h0000);
    add_row("ld_fill", 5, 1, 0, 0, 0, 16'h3000);   // the fifth send finds no credit.
    add_row("st_fill", 5, 0, 1, 0, 0, 16'h4000);
    add_row("stall_hold", 3, 0, 0, 0, 0, 16'h0000);
    add_row("rr_drain", 10, 0, 0, 1, 0, 16'h0000);
    add_row("random_mix", 40, 0, 0, 0, 1, 16'h0000);
    add_row("final_drain", 12, 0, 0, 1, 0, 16'h0000);
    total = 0;
    foreach (rows[i]) total += rows[i].cycles;
    cycle_limit = 2 * total + 50;

    repeat (16) @(posedge i_clk);
    @(negedge i_clk);
    i_reset_n = 1'b1;
    @(negedge i_clk);

    foreach (rows[i]) begin
      for (int n = 0; n < rows[i].cycles; n++) begin
        check_outputs(rows[i].name);
        r = lcg_next();
        i_ld_send   = rows[i].rnd ? r[20] : rows[i].ld_send;
        i_st_send   = rows[i].rnd ? r[21] : rows[i].st_send;
        i_out_ready = rows[i].rnd ? (r[22] | r[23]) : rows[i].ready;
        i_ld_addr   = rows[i].base + 16'(n);
        i_st_addr   = rows[i].base + 16'(n);
        if (rows[i].rnd) begin
          r = lcg_next();
          i_ld_addr = r[15:0];
          i_st_addr = r[31:16];
        end
        r = lcg_next();
        i_st_data = r[15:0];
        model_step();
        @(negedge i_clk);
      end
    end

    // everything drained, so both senders hold their full credit again.
    check_outputs("end_state");
    compare_value("end_state", "ld credits", `CRD_DEPTH, o_ld_credits);
    compare_value("end_state", "st credits", `CRD_DEPTH, o_st_credits);
    compare_value("end_state", "out valid", 0, o_out_valid);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/crd_pkg.sv
rtl/crd_lane_if.sv
rtl/credit_sender.sv
rtl/credit_receiver.sv
rtl/lane_merge.sv
rtl/credit_link_top.sv
test/credit_link_tb.sv
